// File: csr_pkg.sv
package csr_pkg;

    localparam int CSR_ADDR_W = 14;
    localparam int XLEN       = 32;
    localparam int STABLE_W   = 64;
    localparam int IRQ_W      = 9;

    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
    typedef logic [XLEN-1:0]       csr_data_t;
    typedef logic [5:0]            ecode_t;
    typedef logic [8:0]            esubcode_t;

    // address map
    localparam csr_addr_t CSR_CRMD      = 14'h000;
    localparam csr_addr_t CSR_PRMD      = 14'h001;
    localparam csr_addr_t CSR_ECTL      = 14'h004;
    localparam csr_addr_t CSR_ESTAT     = 14'h005;
    localparam csr_addr_t CSR_ERA       = 14'h006;
    localparam csr_addr_t CSR_EENTRY    = 14'h00c;
    localparam csr_addr_t CSR_SAVE0     = 14'h030;
    localparam csr_addr_t CSR_SAVE1     = 14'h031;
    localparam csr_addr_t CSR_SAVE2     = 14'h032;
    localparam csr_addr_t CSR_SAVE3     = 14'h033;
    localparam csr_addr_t CSR_TID       = 14'h040;
    localparam csr_addr_t CSR_TCFG      = 14'h041;
    localparam csr_addr_t CSR_TVAL      = 14'h042;
    localparam csr_addr_t CSR_CNTC      = 14'h043;
    localparam csr_addr_t CSR_TICLR     = 14'h044;
    localparam csr_addr_t CSR_PERF_BASE = 14'h200;

    // field positions, low bit plus width for multi-bit fields
    localparam int PLV_W          = 2;
    localparam int DAT_W          = 2;
    localparam int CRMD_PLV_LO    = 0;
    localparam int CRMD_IE        = 2;
    localparam int CRMD_DA        = 3;
    localparam int CRMD_PG        = 4;
    localparam int CRMD_DATF_LO   = 5;
    localparam int CRMD_DATM_LO   = 7;
    localparam int PRMD_PPLV_LO   = 0;
    localparam int PRMD_PIE       = 2;
    localparam int IS_W           = 13;
    localparam int ECTL_LIE_LO    = 0;
    localparam int SWI_W          = 2;
    localparam int ESTAT_IS_LO    = 0;
    localparam int ESTAT_HWI_LO   = 2;
    localparam int ESTAT_TI       = 11;
    localparam int ESTAT_ECODE_LO = 16;
    localparam int ESTAT_ESUB_LO  = 22;
    localparam int INITVAL_W      = 30;
    localparam int TCFG_EN        = 0;
    localparam int TCFG_PERIODIC  = 1;
    localparam int TCFG_INITVAL_LO = 2;
    localparam int TICLR_CLR      = 0;
    localparam int EENTRY_VA_W    = 26;
    localparam int EENTRY_VA_LO   = 6;

    // one-hot write selects, one per writable register
    localparam int WSEL_W      = 14;
    localparam int WSEL_CRMD   = 0;
    localparam int WSEL_PRMD   = 1;
    localparam int WSEL_ECTL   = 2;
    localparam int WSEL_ESTAT  = 3;
    localparam int WSEL_ERA    = 4;
    localparam int WSEL_EENTRY = 5;
    localparam int WSEL_SAVE0  = 6;
    localparam int WSEL_TID    = 10;
    localparam int WSEL_TCFG   = 11;
    localparam int WSEL_CNTC   = 12;
    localparam int WSEL_TICLR  = 13;

    typedef logic [WSEL_W-1:0] csr_wsel_t;

endpackage

// File: csr_write_decode.sv
module csr_write_decode
    import csr_pkg::*;
(
    input  logic      we1_i,
    input  csr_addr_t waddr1_i,
    input  csr_data_t wdata1_i,
    input  logic      we2_i,
    input  csr_addr_t waddr2_i,
    input  csr_data_t wdata2_i,
    output csr_wsel_t wsel_o,
    output csr_data_t wdata_o
);

    logic      we;
    csr_addr_t waddr;

    // port 1 has priority, port 2 is dropped on collision
    assign we      = we1_i | we2_i;
    assign waddr   = we1_i ? waddr1_i : waddr2_i;
    assign wdata_o = we1_i ? wdata1_i : wdata2_i;

    always_comb begin
        wsel_o = '0;
        if (we) begin
            case (waddr)
                CSR_CRMD:   wsel_o[WSEL_CRMD]     = 1'b1;
                CSR_PRMD:   wsel_o[WSEL_PRMD]     = 1'b1;
                CSR_ECTL:   wsel_o[WSEL_ECTL]     = 1'b1;
                CSR_ESTAT:  wsel_o[WSEL_ESTAT]    = 1'b1;
                CSR_ERA:    wsel_o[WSEL_ERA]      = 1'b1;
                CSR_EENTRY: wsel_o[WSEL_EENTRY]   = 1'b1;
                CSR_SAVE0:  wsel_o[WSEL_SAVE0]    = 1'b1;
                CSR_SAVE1:  wsel_o[WSEL_SAVE0+1]  = 1'b1;
                CSR_SAVE2:  wsel_o[WSEL_SAVE0+2]  = 1'b1;
                CSR_SAVE3:  wsel_o[WSEL_SAVE0+3]  = 1'b1;
                CSR_TID:    wsel_o[WSEL_TID]      = 1'b1;
                CSR_TCFG:   wsel_o[WSEL_TCFG]     = 1'b1;
                CSR_CNTC:   wsel_o[WSEL_CNTC]     = 1'b1;
                CSR_TICLR:  wsel_o[WSEL_TICLR]    = 1'b1;
                // tval is read only
                default:    wsel_o                = '0;
            endcase
        end
    end

endmodule

// File: csr_priv_regs.sv
module csr_priv_regs
    import csr_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  csr_wsel_t        wsel_i,
    input  csr_data_t        wdata_i,
    input  logic             excp_flush_i,
    input  logic             ertn_flush_i,
    input  ecode_t           ecode_i,
    input  esubcode_t        esubcode_i,
    input  csr_data_t        era_i,
    input  logic [IRQ_W-1:0] irq_i,
    input  logic             ti_i,
    output csr_data_t        crmd_o,
    output csr_data_t        prmd_o,
    output csr_data_t        ectl_o,
    output csr_data_t        estat_o,
    output csr_data_t        era_o,
    output csr_data_t        eentry_o,
    output csr_data_t        save0_o,
    output csr_data_t        save1_o,
    output csr_data_t        save2_o,
    output csr_data_t        save3_o,
    output logic [PLV_W-1:0] plv_o,
    output logic             has_int_o
);

    logic [PLV_W-1:0]       crmd_plv_q;
    logic                   crmd_ie_q;
    logic                   crmd_da_q;
    logic                   crmd_pg_q;
    logic [DAT_W-1:0]       crmd_datf_q;
    logic [DAT_W-1:0]       crmd_datm_q;
    logic [PLV_W-1:0]       prmd_pplv_q;
    logic                   prmd_pie_q;
    logic [IS_W-1:0]        ectl_lie_q;
    logic [SWI_W-1:0]       estat_swi_q;
    logic [IRQ_W-1:0]       estat_hwi_q;
    ecode_t                 estat_ecode_q;
    esubcode_t              estat_esub_q;
    csr_data_t              era_q;
    logic [EENTRY_VA_W-1:0] eentry_va_q;
    csr_data_t              save_q [4];
    logic [IS_W-1:0]        estat_is;

    always_ff @(posedge clk) begin
        if (rst) begin
            crmd_plv_q  <= '0;
            crmd_ie_q   <= 1'b0;
            crmd_da_q   <= 1'b1;
            crmd_pg_q   <= 1'b0;
            crmd_datf_q <= '0;
            crmd_datm_q <= '0;
        end else if (excp_flush_i) begin
            crmd_plv_q <= '0;
            crmd_ie_q  <= 1'b0;
        end else if (ertn_flush_i) begin
            crmd_plv_q <= prmd_pplv_q;
            crmd_ie_q  <= prmd_pie_q;
        end else if (wsel_i[WSEL_CRMD]) begin
            crmd_plv_q  <= wdata_i[CRMD_PLV_LO +: PLV_W];
            crmd_ie_q   <= wdata_i[CRMD_IE];
            crmd_da_q   <= wdata_i[CRMD_DA];
            crmd_pg_q   <= wdata_i[CRMD_PG];
            crmd_datf_q <= wdata_i[CRMD_DATF_LO +: DAT_W];
            crmd_datm_q <= wdata_i[CRMD_DATM_LO +: DAT_W];
        end
    end

    // exception entry stacks plv and ie
    always_ff @(posedge clk) begin
        if (rst) begin
            prmd_pplv_q <= '0;
            prmd_pie_q  <= 1'b0;
        end else if (excp_flush_i) begin
            prmd_pplv_q <= crmd_plv_q;
            prmd_pie_q  <= crmd_ie_q;
        end else if (wsel_i[WSEL_PRMD]) begin
            prmd_pplv_q <= wdata_i[PRMD_PPLV_LO +: PLV_W];
            prmd_pie_q  <= wdata_i[PRMD_PIE];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ectl_lie_q <= '0;
        end else if (wsel_i[WSEL_ECTL]) begin
            ectl_lie_q <= wdata_i[ECTL_LIE_LO +: IS_W];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            estat_swi_q   <= '0;
            estat_hwi_q   <= '0;
            estat_ecode_q <= '0;
            estat_esub_q  <= '0;
        end else begin
            estat_hwi_q <= irq_i;
            if (excp_flush_i) begin
                estat_ecode_q <= ecode_i;
                estat_esub_q  <= esubcode_i;
            end else if (wsel_i[WSEL_ESTAT]) begin
                estat_swi_q <= wdata_i[ESTAT_IS_LO +: SWI_W];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (excp_flush_i) begin
            era_q <= era_i;
        end else if (wsel_i[WSEL_ERA]) begin
            era_q <= wdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (wsel_i[WSEL_EENTRY]) begin
            eentry_va_q <= wdata_i[EENTRY_VA_LO +: EENTRY_VA_W];
        end
        for (int k = 0; k < 4; k++) begin
            if (wsel_i[WSEL_SAVE0+k]) begin
                save_q[k] <= wdata_i;
            end
        end
    end

    // register views, undefined bits read 0
    always_comb begin
        crmd_o = '0;
        crmd_o[CRMD_PLV_LO +: PLV_W]  = crmd_plv_q;
        crmd_o[CRMD_IE]               = crmd_ie_q;
        crmd_o[CRMD_DA]               = crmd_da_q;
        crmd_o[CRMD_PG]               = crmd_pg_q;
        crmd_o[CRMD_DATF_LO +: DAT_W] = crmd_datf_q;
        crmd_o[CRMD_DATM_LO +: DAT_W] = crmd_datm_q;

        prmd_o = '0;
        prmd_o[PRMD_PPLV_LO +: PLV_W] = prmd_pplv_q;
        prmd_o[PRMD_PIE]              = prmd_pie_q;

        ectl_o = '0;
        ectl_o[ECTL_LIE_LO +: IS_W] = ectl_lie_q;

        estat_o = '0;
        estat_o[ESTAT_IS_LO +: SWI_W]                = estat_swi_q;
        estat_o[ESTAT_HWI_LO +: IRQ_W]               = estat_hwi_q;
        estat_o[ESTAT_TI]                            = ti_i;
        estat_o[ESTAT_ECODE_LO +: $bits(ecode_t)]    = estat_ecode_q;
        estat_o[ESTAT_ESUB_LO +: $bits(esubcode_t)]  = estat_esub_q;

        eentry_o = '0;
        eentry_o[EENTRY_VA_LO +: EENTRY_VA_W] = eentry_va_q;
    end

    assign era_o   = era_q;
    assign save0_o = save_q[0];
    assign save1_o = save_q[1];
    assign save2_o = save_q[2];
    assign save3_o = save_q[3];

    assign estat_is  = estat_o[ESTAT_IS_LO +: IS_W];
    assign has_int_o = (|(ectl_lie_q & estat_is)) & crmd_ie_q;

    // privilege level seen by the pipeline in the flush cycle
    assign plv_o = excp_flush_i ? '0 : (ertn_flush_i ? prmd_pplv_q : crmd_plv_q);

endmodule

// File: csr_timer.sv
module csr_timer
    import csr_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  csr_wsel_t           wsel_i,
    input  csr_data_t           wdata_i,
    output csr_data_t           tcfg_o,
    output csr_data_t           tval_o,
    output csr_data_t           cntc_o,
    output csr_data_t           tid_o,
    output logic                ti_o,
    output logic [STABLE_W-1:0] timer_64_o
);

    logic                 tcfg_en_q;
    logic                 tcfg_periodic_q;
    logic [INITVAL_W-1:0] tcfg_initval_q;
    logic                 timer_en_q;
    csr_data_t            tval_q;
    logic                 ti_q;
    logic [STABLE_W-1:0]  stable_q;
    csr_data_t            cntc_q;
    csr_data_t            tid_q;
    logic                 tcfg_we;
    logic                 ticlr_clr;
    logic                 expire;

    assign tcfg_we   = wsel_i[WSEL_TCFG];
    assign ticlr_clr = wsel_i[WSEL_TICLR] & wdata_i[TICLR_CLR];
    assign expire    = timer_en_q & (tval_q == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            tcfg_en_q       <= 1'b0;
            tcfg_periodic_q <= 1'b0;
            tcfg_initval_q  <= '0;
        end else if (tcfg_we) begin
            tcfg_en_q       <= wdata_i[TCFG_EN];
            tcfg_periodic_q <= wdata_i[TCFG_PERIODIC];
            tcfg_initval_q  <= wdata_i[TCFG_INITVAL_LO +: INITVAL_W];
        end
    end

    // countdown, initval counts in units of four cycles
    always_ff @(posedge clk) begin
        if (rst) begin
            timer_en_q <= 1'b0;
            tval_q     <= '0;
        end else if (tcfg_we) begin
            timer_en_q <= wdata_i[TCFG_EN];
            tval_q     <= {wdata_i[TCFG_INITVAL_LO +: INITVAL_W], 2'b00};
        end else if (expire) begin
            timer_en_q <= tcfg_periodic_q;
            tval_q     <= tcfg_periodic_q ? {tcfg_initval_q, 2'b00} : '1;
        end else if (timer_en_q) begin
            tval_q <= tval_q - 1'b1;
        end
    end

    // clear beats a same-cycle expiry
    always_ff @(posedge clk) begin
        if (rst) begin
            ti_q <= 1'b0;
        end else if (ticlr_clr) begin
            ti_q <= 1'b0;
        end else if (expire) begin
            ti_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stable_q <= '0;
            cntc_q   <= '0;
            tid_q    <= '0;
        end else begin
            stable_q <= stable_q + 1'b1;
            if (wsel_i[WSEL_CNTC]) begin
                cntc_q <= wdata_i;
            end
            if (wsel_i[WSEL_TID]) begin
                tid_q <= wdata_i;
            end
        end
    end

    always_comb begin
        tcfg_o = '0;
        tcfg_o[TCFG_EN]                       = tcfg_en_q;
        tcfg_o[TCFG_PERIODIC]                 = tcfg_periodic_q;
        tcfg_o[TCFG_INITVAL_LO +: INITVAL_W]  = tcfg_initval_q;
    end

    assign tval_o     = tval_q;
    assign cntc_o     = cntc_q;
    assign tid_o      = tid_q;
    assign ti_o       = ti_q;
    assign timer_64_o = stable_q + {{(STABLE_W-XLEN){cntc_q[XLEN-1]}}, cntc_q};

endmodule

// File: csr_perf_counters.sv
module csr_perf_counters
    import csr_pkg::*;
#(
    parameter int NUM_PERF_EVENTS = 4
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [NUM_PERF_EVENTS-1:0] perf_event_i,
    input  csr_addr_t                  raddr_i,
    output csr_data_t                  rdata_o
);

    csr_data_t cnt_q [NUM_PERF_EVENTS];

    // one event per cycle at most, wraps at 2^32
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < NUM_PERF_EVENTS; k++) begin
                cnt_q[k] <= '0;
            end
        end else begin
            for (int k = 0; k < NUM_PERF_EVENTS; k++) begin
                cnt_q[k] <= cnt_q[k] + XLEN'(perf_event_i[k]);
            end
        end
    end

    // counter k sits at base + k
    always_comb begin
        rdata_o = '0;
        for (int k = 0; k < NUM_PERF_EVENTS; k++) begin
            if (raddr_i == CSR_PERF_BASE + csr_addr_t'(k)) begin
                rdata_o = cnt_q[k];
            end
        end
    end

endmodule

// File: csr_unit.sv
module csr_unit
    import csr_pkg::*;
#(
    parameter int NUM_PERF_EVENTS = 4
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       we1_i,
    input  csr_addr_t                  waddr1_i,
    input  csr_data_t                  wdata1_i,
    input  logic                       we2_i,
    input  csr_addr_t                  waddr2_i,
    input  csr_data_t                  wdata2_i,
    input  csr_addr_t                  raddr_i,
    output csr_data_t                  rdata_o,
    input  logic                       excp_flush_i,
    input  logic                       ertn_flush_i,
    input  ecode_t                     ecode_i,
    input  esubcode_t                  esubcode_i,
    input  csr_data_t                  era_i,
    input  logic [IRQ_W-1:0]           irq_i,
    input  logic [NUM_PERF_EVENTS-1:0] perf_event_i,
    output logic [PLV_W-1:0]           plv_o,
    output logic                       has_int_o,
    output csr_data_t                  eentry_o,
    output csr_data_t                  era_o,
    output logic [STABLE_W-1:0]        timer_64_o,
    output csr_data_t                  tid_o
);

    csr_wsel_t wsel;
    csr_data_t wdata;
    logic      ti;
    csr_data_t crmd;
    csr_data_t prmd;
    csr_data_t ectl;
    csr_data_t estat;
    csr_data_t save0;
    csr_data_t save1;
    csr_data_t save2;
    csr_data_t save3;
    csr_data_t tcfg;
    csr_data_t tval;
    csr_data_t cntc;
    csr_data_t perf_rdata;
    csr_data_t reg_rdata;

    csr_write_decode u_write_decode (
        .we1_i    (we1_i),
        .waddr1_i (waddr1_i),
        .wdata1_i (wdata1_i),
        .we2_i    (we2_i),
        .waddr2_i (waddr2_i),
        .wdata2_i (wdata2_i),
        .wsel_o   (wsel),
        .wdata_o  (wdata)
    );

    csr_priv_regs u_priv_regs (
        .clk          (clk),
        .rst          (rst),
        .wsel_i       (wsel),
        .wdata_i      (wdata),
        .excp_flush_i (excp_flush_i),
        .ertn_flush_i (ertn_flush_i),
        .ecode_i      (ecode_i),
        .esubcode_i   (esubcode_i),
        .era_i        (era_i),
        .irq_i        (irq_i),
        .ti_i         (ti),
        .crmd_o       (crmd),
        .prmd_o       (prmd),
        .ectl_o       (ectl),
        .estat_o      (estat),
        .era_o        (era_o),
        .eentry_o     (eentry_o),
        .save0_o      (save0),
        .save1_o      (save1),
        .save2_o      (save2),
        .save3_o      (save3),
        .plv_o        (plv_o),
        .has_int_o    (has_int_o)
    );

    csr_timer u_timer (
        .clk        (clk),
        .rst        (rst),
        .wsel_i     (wsel),
        .wdata_i    (wdata),
        .tcfg_o     (tcfg),
        .tval_o     (tval),
        .cntc_o     (cntc),
        .tid_o      (tid_o),
        .ti_o       (ti),
        .timer_64_o (timer_64_o)
    );

    csr_perf_counters #(
        .NUM_PERF_EVENTS (NUM_PERF_EVENTS)
    ) u_perf_counters (
        .clk          (clk),
        .rst          (rst),
        .perf_event_i (perf_event_i),
        .raddr_i      (raddr_i),
        .rdata_o      (perf_rdata)
    );

    // ticlr and unmapped addresses fall to zero
    always_comb begin
        case (raddr_i)
            CSR_CRMD:   reg_rdata = crmd;
            CSR_PRMD:   reg_rdata = prmd;
            CSR_ECTL:   reg_rdata = ectl;
            CSR_ESTAT:  reg_rdata = estat;
            CSR_ERA:    reg_rdata = era_o;
            CSR_EENTRY: reg_rdata = eentry_o;
            CSR_SAVE0:  reg_rdata = save0;
            CSR_SAVE1:  reg_rdata = save1;
            CSR_SAVE2:  reg_rdata = save2;
            CSR_SAVE3:  reg_rdata = save3;
            CSR_TID:    reg_rdata = tid_o;
            CSR_TCFG:   reg_rdata = tcfg;
            CSR_TVAL:   reg_rdata = tval;
            CSR_CNTC:   reg_rdata = cntc;
            default:    reg_rdata = '0;
        endcase
    end

    assign rdata_o = reg_rdata | perf_rdata;

endmodule

// File: tb_csr_unit.sv
module tb_csr_unit;
    import csr_pkg::*;

    localparam int NUM_EVENTS = 4;

    logic                  clk;
    logic                  rst;
    logic                  we1;
    csr_addr_t             waddr1;
    csr_data_t             wdata1;
    logic                  we2;
    csr_addr_t             waddr2;
    csr_data_t             wdata2;
    csr_addr_t             raddr;
    csr_data_t             rdata;
    logic                  excp_flush;
    logic                  ertn_flush;
    ecode_t                ecode;
    esubcode_t             esubcode;
    csr_data_t             era_in;
    logic [IRQ_W-1:0]      irq;
    logic [NUM_EVENTS-1:0] perf_event;
    logic [PLV_W-1:0]      plv;
    logic                  has_int;
    csr_data_t             eentry;
    csr_data_t             era_out;
    logic [STABLE_W-1:0]   timer_64;
    csr_data_t             tid;

    string       test_name;
    int          test_errors;
    int          total_errors;
    int          tests_run;
    int          tests_failed;
    int          checks;
    logic [31:0] event_count [NUM_EVENTS];
    logic [31:0] rng_state;
    logic [63:0] cycle_count;
    logic [63:0] sample_value;
    logic [63:0] sample_cycle;
    longint      watchdog_limit = 0;

    csr_unit #(
        .NUM_PERF_EVENTS (NUM_EVENTS)
    ) u_csr_unit (
        .clk          (clk),
        .rst          (rst),
        .we1_i        (we1),
        .waddr1_i     (waddr1),
        .wdata1_i     (wdata1),
        .we2_i        (we2),
        .waddr2_i     (waddr2),
        .wdata2_i     (wdata2),
        .raddr_i      (raddr),
        .rdata_o      (rdata),
        .excp_flush_i (excp_flush),
        .ertn_flush_i (ertn_flush),
        .ecode_i      (ecode),
        .esubcode_i   (esubcode),
        .era_i        (era_in),
        .irq_i        (irq),
        .perf_event_i (perf_event),
        .plv_o        (plv),
        .has_int_o    (has_int),
        .eentry_o     (eentry),
        .era_o        (era_out),
        .timer_64_o   (timer_64),
        .tid_o        (tid)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int open_patterns();
        return $fopen("csr_patterns.txt", "r");
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic skip_line(input int fd);
        int c;
        c = $fgetc(fd);
        while (c != 10 && c != -1) begin
            c = $fgetc(fd);
        end
    endtask

    task automatic compare_value(input logic [63:0] expected, input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("CHECK FAILED test=%s expected=%h actual=%h", test_name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic expect_args(input int got, input int want, input string op);
        if (got != want) begin
            $display("pattern line for '%s' has %0d arguments, %0d expected", op, got, want);
            test_errors++;
        end
    endtask

    task automatic drive_write(input logic p1, input logic p2, input logic [31:0] a1,
                               input logic [31:0] d1, input logic [31:0] a2,
                               input logic [31:0] d2);
        we1    = p1;
        waddr1 = csr_addr_t'(a1);
        wdata1 = d1;
        we2    = p2;
        waddr2 = csr_addr_t'(a2);
        wdata2 = d2;
        next_cycle();
        we1 = 1'b0;
        we2 = 1'b0;
    endtask

    // one random event vector per cycle, counted here as driven
    task automatic run_events(input int n);
        for (int i = 0; i < n; i++) begin
            rng_state  = next_random(rng_state);
            perf_event = rng_state[NUM_EVENTS-1:0];
            for (int k = 0; k < NUM_EVENTS; k++) begin
                event_count[k] = event_count[k] + rng_state[k];
            end
            next_cycle();
        end
        perf_event = '0;
    endtask

    // budget is the waited cycles plus a margin per line
    task automatic compute_timeout(output longint limit);
        int     fd;
        int     n;
        int     lines;
        longint cycles;
        string  op;
        lines  = 0;
        cycles = 0;
        fd     = open_patterns();
        if (fd != 0) begin
            while ($fscanf(fd, "%s", op) == 1) begin
                lines++;
                if (op == "wait" || op == "events") begin
                    if ($fscanf(fd, "%d", n) == 1) begin
                        cycles += n;
                    end
                end
                skip_line(fd);
            end
            $fclose(fd);
        end
        limit = (cycles + 20 * (lines + 1)) * 10;
    endtask

    initial begin
        wait (watchdog_limit != 0);
        #(watchdog_limit);
        $display("timeout: the pattern run did not finish in %0d time units", watchdog_limit);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        int          fd;
        int          nargs;
        int          n;
        string       op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;

        clk          = 1'b0;
        rst          = 1'b1;
        we1          = 1'b0;
        waddr1       = '0;
        wdata1       = '0;
        we2          = 1'b0;
        waddr2       = '0;
        wdata2       = '0;
        raddr        = '0;
        excp_flush   = 1'b0;
        ertn_flush   = 1'b0;
        ecode        = '0;
        esubcode     = '0;
        era_in       = '0;
        irq          = '0;
        perf_event   = '0;
        cycle_count  = '0;
        rng_state    = 32'h2cde;
        test_name    = "none";
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        checks       = 0;
        for (int k = 0; k < NUM_EVENTS; k++) begin
            event_count[k] = '0;
        end

        compute_timeout(watchdog_limit);
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        fd = open_patterns();
        if (fd == 0) begin
            $display("could not open the pattern file csr_patterns.txt");
            total_errors++;
        end else begin
            while ($fscanf(fd, "%s", op) == 1) begin
                if (op[0] == "#") begin
                    skip_line(fd);
                end else begin
                    case (op)
                        "test": begin
                            nargs = $fscanf(fd, "%s", test_name);
                            test_errors = 0;
                            expect_args(nargs, 1, op);
                        end
                        "end": begin
                            tests_run++;
                            if (test_errors == 0) begin
                                $display("test %s: passed", test_name);
                            end else begin
                                $display("test %s: failed, %0d errors", test_name, test_errors);
                                tests_failed++;
                            end
                            total_errors += test_errors;
                            test_errors = 0;
                        end
                        "wr1", "wr2": begin
                            nargs = $fscanf(fd, "%h %h", a, b);
                            expect_args(nargs, 2, op);
                            drive_write(op == "wr1", op == "wr2", a, b, a, b);
                        end
                        "wrb": begin
                            nargs = $fscanf(fd, "%h %h %h %h", a, b, c, d);
                            expect_args(nargs, 4, op);
                            drive_write(1'b1, 1'b1, a, b, c, d);
                        end
                        "excp": begin
                            nargs = $fscanf(fd, "%h %h %h", a, b, c);
                            expect_args(nargs, 3, op);
                            excp_flush = 1'b1;
                            ecode      = a[5:0];
                            esubcode   = b[8:0];
                            era_in     = c;
                            next_cycle();
                            excp_flush = 1'b0;
                        end
                        "ertn": begin
                            ertn_flush = 1'b1;
                            next_cycle();
                            ertn_flush = 1'b0;
                        end
                        "irq": begin
                            nargs = $fscanf(fd, "%h", a);
                            expect_args(nargs, 1, op);
                            irq = a[IRQ_W-1:0];
                        end
                        "events": begin
                            nargs = $fscanf(fd, "%d", n);
                            expect_args(nargs, 1, op);
                            run_events(n);
                        end
                        "wait": begin
                            nargs = $fscanf(fd, "%d", n);
                            expect_args(nargs, 1, op);
                            repeat (n) next_cycle();
                        end
                        "rd": begin
                            nargs = $fscanf(fd, "%h %h", a, b);
                            expect_args(nargs, 2, op);
                            raddr = csr_addr_t'(a);
                            @(negedge clk);
                            compare_value(b, rdata);
                            // era, eentry and tid also leave on ports of their own
                            if (raddr == CSR_ERA) begin
                                compare_value(b, era_out);
                            end
                            if (raddr == CSR_EENTRY) begin
                                compare_value(b, eentry);
                            end
                            if (raddr == CSR_TID) begin
                                compare_value(b, tid);
                            end
                            next_cycle();
                        end
                        "plv", "int": begin
                            nargs = $fscanf(fd, "%h", a);
                            expect_args(nargs, 1, op);
                            @(negedge clk);
                            compare_value(a, (op == "plv") ? 64'(plv) : 64'(has_int));
                            next_cycle();
                        end
                        "perf": begin
                            nargs = $fscanf(fd, "%d", n);
                            expect_args(nargs, 1, op);
                            raddr = CSR_PERF_BASE + csr_addr_t'(n);
                            @(negedge clk);
                            compare_value(event_count[n], rdata);
                            next_cycle();
                        end
                        "tsample": begin
                            @(negedge clk);
                            sample_value = timer_64;
                            sample_cycle = cycle_count;
                            next_cycle();
                        end
                        "tdiff": begin
                            nargs = $fscanf(fd, "%h", a);
                            expect_args(nargs, 1, op);
                            @(negedge clk);
                            compare_value(sample_value + (cycle_count - sample_cycle)
                                          + {{32{a[31]}}, a}, timer_64);
                            next_cycle();
                        end
                        default: begin
                            $display("unknown operation '%s' in the pattern file", op);
                            total_errors++;
                        end
                    endcase
                end
            end
            $fclose(fd);
        end

        // errors outside a closed test still count
        total_errors += test_errors;

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, total_errors);
        if (total_errors == 0 && tests_run > 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: csr_patterns.txt
# op and arguments; addresses and data in hex, wait/events/perf counts in decimal
# wr1|wr2 addr data, wrb a1 d1 a2 d2, excp ecode esub era, ertn, irq lines, rd addr exp,
# plv exp, int exp, perf k, tsample, tdiff offset, test name, end
test write_read
int 0
rd 0000 00000008
rd 0040 00000000
rd 0041 00000000
rd 0043 00000000
wr1 0000 ffffffff
rd 0000 000001ff
wr2 0001 ffffffff
rd 0001 00000007
wr1 0004 ffffffff
rd 0004 00001fff
wr1 0005 ffffffff
rd 0005 00000003
int 1
wr1 000c ffffffff
rd 000c ffffffc0
wr1 0006 12345678
rd 0006 12345678
wr1 0042 ffffffff
rd 0042 00000000
rd 0007 00000000
rd 0204 00000000
wr2 0030 a5a5a5a5
wr2 0033 5a5a5a5a
wrb 0031 11111111 0031 22222222
rd 0031 11111111
wrb 0032 33333333 0033 44444444
rd 0032 33333333
rd 0033 5a5a5a5a
rd 0030 a5a5a5a5
wr2 0040 cafef00d
rd 0040 cafef00d
wr1 0005 00000000
wr1 0004 00000000
int 0
end
test excp_ertn
wr1 0000 00000007
wr1 0001 00000000
plv 3
excp 0d 1a5 9000abcd
plv 0
rd 0000 00000000
rd 0001 00000007
rd 0006 9000abcd
rd 0005 694d0000
ertn
rd 0000 00000007
plv 3
end
test timer
wr1 0041 00000009
rd 0042 00000008
rd 0041 00000009
wait 6
rd 0005 694d0000
rd 0005 694d0800
rd 0042 ffffffff
wr1 0044 00000001
rd 0005 694d0000
wr1 0041 00000007
wait 5
rd 0005 694d0800
wr1 0044 00000001
rd 0005 694d0000
wait 2
rd 0005 694d0800
wr1 0041 00000000
wr1 0044 00000001
rd 0005 694d0000
end
test interrupts
int 0
wr1 0004 00000001
int 0
wr1 0005 00000001
int 1
wr1 0000 00000003
int 0
wr1 0000 00000007
int 1
wr1 0005 00000000
wr1 0004 00000004
irq 001
int 0
int 1
irq 002
wait 1
int 0
irq 000
wr1 0004 00000800
wr1 0041 00000005
int 0
wait 4
int 1
wr1 0044 00000001
int 0
wr1 0004 00000000
end
test perf_counters
events 28
perf 0
perf 1
perf 2
perf 3
events 13
perf 0
perf 1
perf 2
perf 3
end
test stable_counter
tsample
wait 11
tdiff 00000000
wr1 0043 fffffc18
tdiff fffffc18
rd 0043 fffffc18
end

// File: csr_unit.f
csr_pkg.sv
csr_write_decode.sv
csr_priv_regs.sv
csr_timer.sv
csr_perf_counters.sv
csr_unit.sv
tb_csr_unit.sv

// File: Bender.yml
package:
  name: csr_unit

sources:
  - csr_pkg.sv
  - csr_write_decode.sv
  - csr_priv_regs.sv
  - csr_timer.sv
  - csr_perf_counters.sv
  - csr_unit.sv
  - target: test
    files:
      - tb_csr_unit.sv
